// ==== Makefile ====
# Verilator flow for the MIPS Avalon core

TOP       ?= tbMipsCpuBus
FLIST     ?= list.f
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== list.f ====
+incdir+src
src/mipsPkg.sv
src/decodeIf.sv
src/instrDecoder.sv
src/regFile.sv
src/alu.sv
src/cpuControl.sv
src/mipsCpuBus.sv
tb/tbMipsCpuBus.sv

// ==== src/alu.sv ====
// Integer ALU
`default_nettype none

module alu (
    decodeIf.alu          dec,
    input  mipsPkg::wordT opA,
    input  mipsPkg::wordT opB,
    output mipsPkg::wordT result,
    output logic          equal
);

    mipsPkg::wordT operand;
    logic          lessSigned;
    logic          lessUnsigned;

    assign operand      = dec.useImm ? dec.imm : opB;
    assign lessSigned   = $signed(opA) < $signed(operand);
    assign lessUnsigned = opA < operand;

    // Branch compare always uses rt
    assign equal = (opA == opB);

    always_comb begin
        case (dec.aluOp)
            mipsPkg::AluAdd:  result = opA + operand;
            mipsPkg::AluSub:  result = opA - operand;
            mipsPkg::AluAnd:  result = opA & operand;
            mipsPkg::AluOr:   result = opA | operand;
            mipsPkg::AluXor:  result = opA ^ operand;
            mipsPkg::AluSlt:  result = {31'b0, lessSigned};
            mipsPkg::AluSltu: result = {31'b0, lessUnsigned};
            // Shift amount comes from the instruction, value from rt
            mipsPkg::AluSll:  result = opB << dec.shamt;
            mipsPkg::AluSrl:  result = opB >> dec.shamt;
            mipsPkg::AluSra:  result = $signed(opB) >>> dec.shamt;
            mipsPkg::AluLui:  result = {dec.imm[15:0], 16'b0};
            default:          result = opA + operand;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/cpuControl.sv ====
// Control FSM, PC and Avalon master
`default_nettype none
`include "cpu_settings.svh"

module cpuControl (
    input  logic             clk,
    input  logic             reset,
    decodeIf.control         dec,
    output mipsPkg::wordT    instr,
    input  mipsPkg::wordT    rsData,
    input  mipsPkg::wordT    rtData,
    input  mipsPkg::wordT    aluResult,
    input  logic             aluEqual,
    output logic             regWriteEn,
    output mipsPkg::regAddrT regWriteAddr,
    output mipsPkg::wordT    regWriteData,
    output logic             active,
    output mipsPkg::wordT    address,
    output mipsPkg::wordT    writedata,
    output logic             read,
    output logic             write,
    output logic [3:0]       byteenable,
    input  logic             waitrequest,
    input  mipsPkg::wordT    readdata
);

    mipsPkg::cpuStateT state;
    mipsPkg::wordT     pc;
    mipsPkg::wordT     instrReg;
    mipsPkg::wordT     pcPlus4;
    mipsPkg::wordT     branchTarget;
    mipsPkg::wordT     jumpTarget;
    logic              aluClass;
    logic              loadDone;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {dec.imm[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], dec.target, 2'b00};

    assign aluClass = (dec.instrClass == mipsPkg::ClsAluReg) ||
                      (dec.instrClass == mipsPkg::ClsAluImm);
    assign loadDone = (state == mipsPkg::StMemory) && read && !waitrequest;

    // ALU results land in Execute, load data on completion in Memory
    assign regWriteEn   = ((state == mipsPkg::StExecute) && aluClass) || loadDone;
    // Loads are I-type, so dest is already rt
    assign regWriteAddr = dec.dest;
    assign regWriteData = (state == mipsPkg::StMemory) ? readdata : aluResult;

    assign instr      = instrReg;
    assign active     = (state != mipsPkg::StHalt);
    assign byteenable = 4'b1111;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mipsPkg::StFetch;
            pc    <= `CPU_RESET_VECTOR;
            read  <= 1'b0;
            write <= 1'b0;
        end else begin
            case (state)
                mipsPkg::StFetch: begin
                    // First cycle in Fetch checks PC, then the read is issued
                    if (!read) begin
                        if (pc == '0) begin
                            state <= mipsPkg::StHalt;
                        end else begin
                            read    <= 1'b1;
                            address <= pc;
                        end
                    end else if (!waitrequest) begin
                        read     <= 1'b0;
                        instrReg <= readdata;
                        state    <= mipsPkg::StExecute;
                    end
                end
                mipsPkg::StExecute: begin
                    state <= mipsPkg::StFetch;
                    pc    <= pcPlus4;
                    case (dec.instrClass)
                        mipsPkg::ClsBranchEq: pc <= aluEqual ? branchTarget : pcPlus4;
                        mipsPkg::ClsBranchNe: pc <= aluEqual ? pcPlus4 : branchTarget;
                        mipsPkg::ClsJump:     pc <= jumpTarget;
                        mipsPkg::ClsJumpReg:  pc <= rsData;
                        mipsPkg::ClsLoad: begin
                            pc      <= pc;
                            state   <= mipsPkg::StMemory;
                            address <= aluResult;
                            read    <= 1'b1;
                        end
                        mipsPkg::ClsStore: begin
                            pc        <= pc;
                            state     <= mipsPkg::StMemory;
                            address   <= aluResult;
                            writedata <= rtData;
                            write     <= 1'b1;
                        end
                        default: ;
                    endcase
                end
                mipsPkg::StMemory: begin
                    // Request held until the slave drops waitrequest
                    if (!waitrequest) begin
                        read  <= 1'b0;
                        write <= 1'b0;
                        pc    <= pcPlus4;
                        state <= mipsPkg::StFetch;
                    end
                end
                default: begin
                    read  <= 1'b0;
                    write <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/cpu_settings.svh ====
// Core configuration constants
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and address width
`define CPU_WORD_WIDTH 32

// First instruction fetch address
`define CPU_RESET_VECTOR 32'hBFC00000

// Register file size
`define CPU_REG_COUNT 32

// Register mirrored on the debug output
`define CPU_V0_INDEX 2

`endif

// ==== src/decodeIf.sv ====
// Decoded instruction bundle
`default_nettype none

interface decodeIf;

    mipsPkg::instrClassT instrClass;
    mipsPkg::aluOpT      aluOp;
    mipsPkg::regAddrT    rs;
    mipsPkg::regAddrT    rt;
    // rd for R-type, rt for I-type
    mipsPkg::regAddrT    dest;
    logic [4:0]          shamt;
    mipsPkg::wordT       imm;
    logic                useImm;
    logic [25:0]         target;

    modport decoder (
        output instrClass, aluOp, rs, rt, dest, shamt, imm, useImm, target
    );

    modport control (
        input instrClass, rs, rt, dest, imm, target
    );

    modport alu (
        input aluOp, useImm, shamt, imm
    );

endinterface

`default_nettype wire

// ==== src/instrDecoder.sv ====
// Instruction field decoder
`default_nettype none

module instrDecoder (
    input  mipsPkg::wordT instr,
    decodeIf.decoder      dec
);

    mipsPkg::opcodeT opcode;
    mipsPkg::functT  funct;
    logic            zeroExt;

    assign opcode     = mipsPkg::opcodeT'(instr[31:26]);
    assign funct      = mipsPkg::functT'(instr[5:0]);
    assign dec.rs     = instr[25:21];
    assign dec.rt     = instr[20:16];
    assign dec.shamt  = instr[10:6];
    assign dec.target = instr[25:0];
    assign dec.dest   = (opcode == mipsPkg::OpSpecial) ? instr[15:11] : instr[20:16];

    // Logical immediates are zero-extended, the rest sign-extended
    assign zeroExt = (opcode == mipsPkg::OpAndi) || (opcode == mipsPkg::OpOri) ||
                     (opcode == mipsPkg::OpXori);
    assign dec.imm = zeroExt ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        dec.instrClass = mipsPkg::ClsNop;
        dec.aluOp      = mipsPkg::AluAdd;
        dec.useImm     = 1'b1;
        case (opcode)
            mipsPkg::OpSpecial: begin
                dec.instrClass = mipsPkg::ClsAluReg;
                dec.useImm     = 1'b0;
                case (funct)
                    mipsPkg::FnAddu: dec.aluOp = mipsPkg::AluAdd;
                    mipsPkg::FnSubu: dec.aluOp = mipsPkg::AluSub;
                    mipsPkg::FnAnd:  dec.aluOp = mipsPkg::AluAnd;
                    mipsPkg::FnOr:   dec.aluOp = mipsPkg::AluOr;
                    mipsPkg::FnXor:  dec.aluOp = mipsPkg::AluXor;
                    mipsPkg::FnSlt:  dec.aluOp = mipsPkg::AluSlt;
                    mipsPkg::FnSltu: dec.aluOp = mipsPkg::AluSltu;
                    mipsPkg::FnSll:  dec.aluOp = mipsPkg::AluSll;
                    mipsPkg::FnSrl:  dec.aluOp = mipsPkg::AluSrl;
                    mipsPkg::FnSra:  dec.aluOp = mipsPkg::AluSra;
                    mipsPkg::FnJr:   dec.instrClass = mipsPkg::ClsJumpReg;
                    default:         dec.instrClass = mipsPkg::ClsNop;
                endcase
            end
            mipsPkg::OpJ: dec.instrClass = mipsPkg::ClsJump;
            // Branches compare rs with rt, not the immediate
            mipsPkg::OpBeq: begin
                dec.instrClass = mipsPkg::ClsBranchEq;
                dec.useImm     = 1'b0;
            end
            mipsPkg::OpBne: begin
                dec.instrClass = mipsPkg::ClsBranchNe;
                dec.useImm     = 1'b0;
            end
            mipsPkg::OpAddiu: dec.instrClass = mipsPkg::ClsAluImm;
            mipsPkg::OpSlti: begin
                dec.instrClass = mipsPkg::ClsAluImm;
                dec.aluOp      = mipsPkg::AluSlt;
            end
            mipsPkg::OpSltiu: begin
                dec.instrClass = mipsPkg::ClsAluImm;
                dec.aluOp      = mipsPkg::AluSltu;
            end
            mipsPkg::OpAndi: begin
                dec.instrClass = mipsPkg::ClsAluImm;
                dec.aluOp      = mipsPkg::AluAnd;
            end
            mipsPkg::OpOri: begin
                dec.instrClass = mipsPkg::ClsAluImm;
                dec.aluOp      = mipsPkg::AluOr;
            end
            mipsPkg::OpXori: begin
                dec.instrClass = mipsPkg::ClsAluImm;
                dec.aluOp      = mipsPkg::AluXor;
            end
            mipsPkg::OpLui: begin
                dec.instrClass = mipsPkg::ClsAluImm;
                dec.aluOp      = mipsPkg::AluLui;
            end
            mipsPkg::OpLw: dec.instrClass = mipsPkg::ClsLoad;
            mipsPkg::OpSw: dec.instrClass = mipsPkg::ClsStore;
            default:       dec.instrClass = mipsPkg::ClsNop;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/mipsCpuBus.sv ====
// MIPS core with Avalon master
`default_nettype none

module mipsCpuBus (
    input  logic          clk,
    input  logic          reset,
    output logic          active,
    output mipsPkg::wordT registerV0,
    output mipsPkg::wordT address,
    output logic          write,
    output logic          read,
    input  logic          waitrequest,
    output mipsPkg::wordT writedata,
    output logic [3:0]    byteenable,
    input  mipsPkg::wordT readdata
);

    mipsPkg::wordT    instr;
    mipsPkg::wordT    rsData;
    mipsPkg::wordT    rtData;
    mipsPkg::wordT    aluResult;
    logic             aluEqual;
    logic             regWriteEn;
    mipsPkg::regAddrT regWriteAddr;
    mipsPkg::wordT    regWriteData;

    decodeIf decBus ();

    instrDecoder instrDecoder_i (
        .instr (instr),
        .dec   (decBus)
    );

    regFile regFile_i (
        .clk       (clk),
        .reset     (reset),
        .readAddrA (decBus.rs),
        .readAddrB (decBus.rt),
        .readDataA (rsData),
        .readDataB (rtData),
        .writeEn   (regWriteEn),
        .writeAddr (regWriteAddr),
        .writeData (regWriteData),
        .v0        (registerV0)
    );

    alu alu_i (
        .dec    (decBus),
        .opA    (rsData),
        .opB    (rtData),
        .result (aluResult),
        .equal  (aluEqual)
    );

    cpuControl cpuControl_i (
        .clk          (clk),
        .reset        (reset),
        .dec          (decBus),
        .instr        (instr),
        .rsData       (rsData),
        .rtData       (rtData),
        .aluResult    (aluResult),
        .aluEqual     (aluEqual),
        .regWriteEn   (regWriteEn),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData),
        .active       (active),
        .address      (address),
        .writedata    (writedata),
        .read         (read),
        .write        (write),
        .byteenable   (byteenable),
        .waitrequest  (waitrequest),
        .readdata     (readdata)
    );

endmodule

`default_nettype wire

// ==== src/mipsPkg.sv ====
// MIPS core types
`default_nettype none
`include "cpu_settings.svh"

package mipsPkg;

    typedef logic [`CPU_WORD_WIDTH-1:0] wordT;
    typedef logic [4:0] regAddrT;

    // Primary opcodes
    typedef enum logic [5:0] {
        OpSpecial = 6'd0,
        OpJ       = 6'd2,
        OpBeq     = 6'd4,
        OpBne     = 6'd5,
        OpAddiu   = 6'd9,
        OpSlti    = 6'd10,
        OpSltiu   = 6'd11,
        OpAndi    = 6'd12,
        OpOri     = 6'd13,
        OpXori    = 6'd14,
        OpLui     = 6'd15,
        OpLw      = 6'd35,
        OpSw      = 6'd43
    } opcodeT;

    // R-type function codes
    typedef enum logic [5:0] {
        FnSll  = 6'd0,
        FnSrl  = 6'd2,
        FnSra  = 6'd3,
        FnJr   = 6'd8,
        FnAddu = 6'd33,
        FnSubu = 6'd35,
        FnAnd  = 6'd36,
        FnOr   = 6'd37,
        FnXor  = 6'd38,
        FnSlt  = 6'd42,
        FnSltu = 6'd43
    } functT;

    typedef enum logic [1:0] {
        StFetch, StExecute, StMemory, StHalt
    } cpuStateT;

    // Nine classes need a fourth bit
    typedef enum logic [3:0] {
        ClsAluReg, ClsAluImm, ClsLoad, ClsStore, ClsBranchEq,
        ClsBranchNe, ClsJump, ClsJumpReg, ClsNop
    } instrClassT;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt,
        AluSltu, AluSll, AluSrl, AluSra, AluLui
    } aluOpT;

endpackage

`default_nettype wire

// ==== src/regFile.sv ====
// General purpose register file
`default_nettype none
`include "cpu_settings.svh"

module regFile (
    input  logic             clk,
    input  logic             reset,
    input  mipsPkg::regAddrT readAddrA,
    input  mipsPkg::regAddrT readAddrB,
    output mipsPkg::wordT    readDataA,
    output mipsPkg::wordT    readDataB,
    input  logic             writeEn,
    input  mipsPkg::regAddrT writeAddr,
    input  mipsPkg::wordT    writeData,
    output mipsPkg::wordT    v0
);

    // Register zero has no storage
    mipsPkg::wordT regs [1:`CPU_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];
    assign v0        = regs[`CPU_V0_INDEX];

endmodule

`default_nettype wire

// ==== tb/tbMipsCpuBus.sv ====
// MIPS Avalon core testbench
`default_nettype none
`include "cpu_settings.svh"

module tbMipsCpuBus;

    localparam int clkPeriod = 4;
    localparam int progWords = 48;
    localparam int maxStall  = 8;
    // Four bus phases per instruction at most, doubled for margin
    localparam int timeLimit = 2 * progWords * 4 * maxStall * clkPeriod + 10 * clkPeriod;
    localparam logic [31:0] resetVector = `CPU_RESET_VECTOR;
    localparam logic [31:0] dataBase    = 32'h0000_1000;

    logic        clk;
    logic        reset;
    logic        active;
    logic [31:0] registerV0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;

    logic [31:0] progMem [0:63];
    logic [31:0] dataMem [0:31];
    logic [31:0] refProg [0:63];
    logic [31:0] refData [0:31];
    logic [31:0] gotReads[$];
    logic [31:0] gotStoreAddr[$];
    logic [31:0] gotStoreData[$];
    logic [31:0] expReads[$];
    logic [31:0] expStoreAddr[$];
    logic [31:0] expStoreData[$];
    logic [31:0] expV0;
    logic [69:0] prevBus;
    logic        holdPrev;
    logic        resetSeen;
    int          progLen;
    int          errors;
    int          checks;

    mipsCpuBus mipsCpuBus_i (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .registerV0  (registerV0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] fillWord(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ 32'h6C3A_95E1;
    endfunction

    function automatic logic [31:0] readWord(input logic [31:0] prog [0:63],
                                             input logic [31:0] data [0:31],
                                             input logic [31:0] a);
        if (a[31:8] == resetVector[31:8]) return prog[a[7:2]];
        if (a[31:7] == dataBase[31:7]) return data[a[6:2]];
        return fillWord(a);
    endfunction

    function automatic logic [31:0] rType(input int rs, input int rt, input int rd,
                                          input int sh, input int fn);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
    endfunction

    function automatic logic [31:0] iType(input int op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {6'(op), 5'(rs), 5'(rt), imm};
    endfunction

    task automatic emit(input logic [31:0] w);
        progMem[progLen] = w;
        progLen++;
    endtask

    task automatic buildProgram();
        logic [31:0] jumpAddr;
        progLen = 0;
        for (int i = 0; i < 64; i++) progMem[i] = fillWord(resetVector + 32'(4 * i));
        for (int i = 0; i < 32; i++) dataMem[i] = fillWord(dataBase + 32'(4 * i));
        emit(iType(9, 0, 8, 16'h1000));
        emit(iType(9, 0, 9, 16'hFFFB));
        emit(iType(13, 0, 10, 16'h8003));
        emit(iType(15, 0, 11, 16'h8000));
        emit(rType(9, 10, 12, 0, 33));
        emit(rType(10, 9, 13, 0, 35));
        emit(rType(9, 10, 14, 0, 36));
        emit(rType(9, 10, 15, 0, 37));
        emit(rType(9, 10, 16, 0, 38));
        // Signed and unsigned compares of a negative value
        emit(rType(9, 10, 17, 0, 42));
        emit(rType(9, 10, 18, 0, 43));
        emit(rType(0, 10, 19, 4, 0));
        emit(rType(0, 11, 20, 3, 2));
        emit(rType(0, 11, 21, 3, 3));
        emit(iType(12, 9, 22, 16'hF0F0));
        emit(iType(14, 9, 23, 16'hFFFF));
        emit(iType(10, 9, 24, 16'hFFFF));
        emit(iType(11, 9, 25, 16'hFFFF));
        emit(iType(9, 0, 0, 16'h0007));
        for (int r = 12; r <= 25; r++) emit(iType(43, 8, r, 16'((r - 12) * 4)));
        emit(iType(43, 8, 0, 16'h0038));
        // Taken BEQ and BNE, then untaken ones
        emit(iType(4, 17, 25, 16'h0001));
        emit(iType(9, 0, 2, 16'h0BAD));
        emit(iType(5, 17, 18, 16'h0001));
        emit(iType(9, 0, 2, 16'h0BAD));
        emit(iType(4, 17, 18, 16'h0001));
        emit(iType(5, 17, 25, 16'h0001));
        jumpAddr = resetVector + 32'(4 * (progLen + 2));
        emit({6'd2, jumpAddr[27:2]});
        emit(iType(9, 2, 2, 16'h0BAD));
        emit(iType(35, 8, 3, 16'h0004));
        emit(32'hFC00_0000);
        emit(iType(43, 8, 3, 16'h0040));
        emit(iType(35, 8, 2, 16'h0040));
        emit(iType(9, 2, 2, 16'h0001));
        emit(rType(0, 0, 0, 0, 8));
    endtask

    // ISA-level interpreter, one instruction per step, no delay slots
    function automatic logic [31:0] runReference();
        logic [31:0] regs [0:31];
        logic [31:0] pc;
        logic [31:0] ir;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] next;
        int          steps;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        pc = resetVector;
        steps = 0;
        while (pc != '0 && steps < 1000) begin
            expReads.push_back(pc);
            ir = readWord(refProg, refData, pc);
            a = regs[ir[25:21]];
            b = regs[ir[20:16]];
            simm = {{16{ir[15]}}, ir[15:0]};
            next = pc + 32'd4;
            case (ir[31:26])
                6'h00: case (ir[5:0])
                    6'h00: regs[ir[15:11]] = b << ir[10:6];
                    6'h02: regs[ir[15:11]] = b >> ir[10:6];
                    6'h03: regs[ir[15:11]] = $signed(b) >>> ir[10:6];
                    6'h08: next = a;
                    6'h21: regs[ir[15:11]] = a + b;
                    6'h23: regs[ir[15:11]] = a - b;
                    6'h24: regs[ir[15:11]] = a & b;
                    6'h25: regs[ir[15:11]] = a | b;
                    6'h26: regs[ir[15:11]] = a ^ b;
                    6'h2A: regs[ir[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h2B: regs[ir[15:11]] = (a < b) ? 32'd1 : 32'd0;
                    default: ;
                endcase
                6'h02: next = {next[31:28], ir[25:0], 2'b00};
                6'h04: if (a == b) next = next + (simm << 2);
                6'h05: if (a != b) next = next + (simm << 2);
                6'h09: regs[ir[20:16]] = a + simm;
                6'h0A: regs[ir[20:16]] = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                6'h0B: regs[ir[20:16]] = (a < simm) ? 32'd1 : 32'd0;
                6'h0C: regs[ir[20:16]] = a & {16'b0, ir[15:0]};
                6'h0D: regs[ir[20:16]] = a | {16'b0, ir[15:0]};
                6'h0E: regs[ir[20:16]] = a ^ {16'b0, ir[15:0]};
                6'h0F: regs[ir[20:16]] = {ir[15:0], 16'b0};
                6'h23: begin
                    expReads.push_back(a + simm);
                    regs[ir[20:16]] = readWord(refProg, refData, a + simm);
                end
                6'h2B: begin
                    expStoreAddr.push_back(a + simm);
                    expStoreData.push_back(b);
                    if ((a + simm) >> 7 == dataBase >> 7) refData[(a + simm) >> 2 & 31] = b;
                end
                default: ;
            endcase
            regs[0] = '0;
            pc = next;
            steps++;
        end
        return regs[`CPU_V0_INDEX];
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Avalon slave, one forced wait cycle then random stalls
    always @(posedge clk) begin
        if (reset) begin
            waitrequest <= 1'b1;
        end else if ((read || write) && waitrequest) begin
            waitrequest <= ($urandom % 32'd3) == 32'd0;
            readdata    <= readWord(progMem, dataMem, address);
        end else begin
            if (read && !waitrequest) gotReads.push_back(address);
            if (write && !waitrequest) begin
                gotStoreAddr.push_back(address);
                gotStoreData.push_back(writedata);
                checks++;
                if (byteenable !== 4'b1111) begin
                    errors++;
                    $display("[FAIL] %0t byteenable: got %b expected 1111", $time, byteenable);
                end
                if (address[31:7] == dataBase[31:7]) dataMem[address[6:2]] <= writedata;
            end
            waitrequest <= 1'b1;
        end
    end

    // Bus protocol monitor, sampled away from the active edge
    always @(negedge clk) begin
        if (reset || resetSeen) begin
            checks++;
            if (read || write || !active) begin
                errors++;
                $display("Error at %0t: bus request or inactive core around reset", $time);
            end
        end else if (!active && (read || write)) begin
            errors++;
            $display("Error at %0t: bus request after the core halted", $time);
        end
        if (read && address == '0) begin
            errors++;
            $display("Error at %0t: core fetched from address zero", $time);
        end
        if (holdPrev) begin
            checks++;
            if ({read, write, byteenable, address, writedata} !== prevBus) begin
                errors++;
                $display("[FAIL] %0t bus outputs under waitrequest: got %h expected %h",
                         $time, {read, write, byteenable, address, writedata}, prevBus);
            end
        end
        holdPrev  = (read || write) && waitrequest && !reset;
        prevBus   = {read, write, byteenable, address, writedata};
        resetSeen = reset;
    end

    initial begin
        #(timeLimit);
        $display("Timeout: the core did not halt within %0d time units", timeLimit);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hd9b6));
        reset       = 1'b1;
        waitrequest = 1'b1;
        readdata    = '0;
        errors      = 0;
        checks      = 0;
        holdPrev    = 1'b0;
        resetSeen   = 1'b1;
        buildProgram();
        refProg = progMem;
        refData = dataMem;
        expV0 = runReference();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        while (active) @(posedge clk);
        // Quiet window after halt
        repeat (20) @(posedge clk);
        checkWord("first read address", (gotReads.size() > 0) ? gotReads[0] : '0, resetVector);
        checkWord("read count", gotReads.size(), expReads.size());
        for (int i = 0; i < expReads.size() && i < gotReads.size(); i++) begin
            checkWord("read address", gotReads[i], expReads[i]);
        end
        checkWord("store count", gotStoreAddr.size(), expStoreAddr.size());
        for (int i = 0; i < expStoreAddr.size() && i < gotStoreAddr.size(); i++) begin
            checkWord("store address", gotStoreAddr[i], expStoreAddr[i]);
            checkWord("writedata", gotStoreData[i], expStoreData[i]);
        end
        checkWord("registerV0", registerV0, expV0);
        for (int i = 0; i < 32; i++) checkWord("data word", dataMem[i], refData[i]);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
